// ==== files.f ====
hw/harness_pkg.sv
hw/periph_addr_decode.sv
hw/periph_reg_demux.sv
hw/scratch_ram.sv
hw/gpio_cnt.sv
hw/switch_ack_model.sv
hw/ext_periph_harness.sv
testbench/ext_periph_harness_asserts.sv
testbench/tb_ext_periph_harness.sv

// ==== testbench/tb_ext_periph_harness.sv ====
////////////////////////////////////////
// Harness testbench
// Directed tests over the register bus
////////////////////////////////////////

`default_nettype none

module tb_ext_periph_harness
  import harness_pkg::*;
();

  localparam int unsigned SCRATCH_WORDS  = 64;
  localparam int unsigned CNT_MAX        = 8;
  localparam int unsigned NUM_DOMAINS    = 4;
  localparam int unsigned ACK_LATENCY    = 15;
  localparam int unsigned TIMEOUT_CYCLES = 2000;
  localparam int unsigned RSP_WAIT_LIMIT = 4;
  localparam reg_addr_t   GPIO_BASE      = 12'h100;
  localparam reg_addr_t   POWER_BASE     = 12'h200;

  logic                   clk;
  logic                   reset;
  logic                   req;
  logic                   we;
  reg_addr_t              addr;
  reg_data_t              wdata;
  logic                   rsp_valid;
  reg_data_t              rdata;
  logic                   err;
  logic                   gpio_in;
  logic                   gpio_out;
  logic [NUM_DOMAINS-1:0] power_switch_n;
  logic [NUM_DOMAINS-1:0] power_ack_n;
  logic [INTR_W-1:0]      intr;

  int unsigned error_count;
  int unsigned check_count;
  int unsigned test_count;
  int unsigned test_error_base;
  int unsigned cycle_count;
  int unsigned wrap_pulses;
  int unsigned ack_pulses;
  logic [31:0] lcg_state;
  string       test_name;

  ext_periph_harness #(
    .SCRATCH_WORDS(SCRATCH_WORDS),
    .CNT_MAX      (CNT_MAX),
    .NUM_DOMAINS  (NUM_DOMAINS),
    .ACK_LATENCY  (ACK_LATENCY)
  ) UUT (
    .clk_i           (clk),
    .reset_i         (reset),
    .req_i           (req),
    .we_i            (we),
    .addr_i          (addr),
    .wdata_i         (wdata),
    .rsp_valid_o     (rsp_valid),
    .rdata_o         (rdata),
    .err_o           (err),
    .gpio_i          (gpio_in),
    .gpio_o          (gpio_out),
    .power_switch_n_o(power_switch_n),
    .power_ack_n_o   (power_ack_n),
    .intr_o          (intr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Count each interrupt pulse once per high cycle
  always @(negedge clk) begin
    if (!reset) begin
      if (intr[INTR_GPIO_WRAP]) wrap_pulses++;
      if (intr[INTR_POWER_ACK]) ack_pulses++;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string label, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[FAIL] %s %s: expected 0x%08h, actual 0x%08h",
               test_name, label, expected, actual);
    end
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    test_error_base = error_count;
    test_count++;
  endtask

  task automatic end_test();
    $display("test %s finished, %0d errors", test_name, error_count - test_error_base);
  endtask

  // One strobe, then wait for its response
  task automatic bus_access(input logic write, input reg_addr_t access_addr,
                            input reg_data_t data, output reg_data_t rd, output logic rd_err);
    int unsigned waited;
    @(posedge clk);
    req   <= 1'b1;
    we    <= write;
    addr  <= access_addr;
    wdata <= data;
    @(posedge clk);
    req <= 1'b0;
    we  <= 1'b0;
    waited = 1;
    @(negedge clk);
    while (!rsp_valid && waited < RSP_WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!rsp_valid) begin
      error_count++;
      $display("%s: no response to the access at 0x%03h", test_name, access_addr);
    end else begin
      check_value("response latency", 1, waited);
    end
    rd     = rdata;
    rd_err = err;
  endtask

  task automatic check_response(input reg_data_t exp_data, input logic exp_err);
    check_value("rsp_valid_o", 1, rsp_valid);
    check_value("rdata_o", exp_data, rdata);
    check_value("err_o", exp_err, err);
  endtask

  task automatic drive_gpio_edge();
    @(posedge clk);
    gpio_in <= 1'b1;
    repeat (2) @(posedge clk);
    gpio_in <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic test_reset_state();
    reg_data_t rd;
    logic      rd_err;
    begin_test("reset_state");
    @(negedge clk);
    check_value("gpio_o", 0, gpio_out);
    check_value("intr_o", 0, intr);
    check_value("power_switch_n_o", {NUM_DOMAINS{1'b1}}, power_switch_n);
    check_value("power_ack_n_o", {NUM_DOMAINS{1'b1}}, power_ack_n);
    bus_access(1'b0, GPIO_BASE + OFS_CNT, '0, rd, rd_err);
    check_value("counter read", 0, rd);
    check_value("counter err", 0, rd_err);
    end_test();
  endtask

  task automatic test_scratch_mem();
    reg_data_t   model [SCRATCH_WORDS];
    int unsigned words [16];
    reg_data_t   rd;
    logic        rd_err;
    begin_test("scratch_mem");
    for (int i = 0; i < 16; i++) begin
      lcg_state = lcg_next(lcg_state);
      words[i]  = (lcg_state >> 8) % SCRATCH_WORDS;
      lcg_state = lcg_next(lcg_state);
      model[words[i]] = lcg_state;
      bus_access(1'b1, reg_addr_t'(words[i] << 2), lcg_state, rd, rd_err);
      check_value("write rdata", 0, rd);
      check_value("write err", 0, rd_err);
    end
    for (int i = 0; i < 16; i++) begin
      bus_access(1'b0, reg_addr_t'(words[i] << 2), '0, rd, rd_err);
      check_value("read data", model[words[i]], rd);
      check_value("read err", 0, rd_err);
    end
    end_test();
  endtask

  task automatic test_addr_map();
    reg_addr_t bad_addr [3];
    reg_addr_t burst_addr [3];
    reg_data_t burst_data [3];
    logic      burst_err [3];
    reg_data_t rd;
    logic      rd_err;
    begin_test("addr_map");
    bad_addr = '{12'h110, 12'h300, 12'hFFC};
    for (int i = 0; i < 3; i++) begin
      bus_access(1'b0, bad_addr[i], '0, rd, rd_err);
      check_value("unmapped err", 1, rd_err);
      check_value("unmapped rdata", 0, rd);
    end
    // Two scratch words around an unmapped read
    burst_addr = '{12'h010, 12'h300, 12'h020};
    burst_err  = '{1'b0, 1'b1, 1'b0};
    lcg_state = lcg_next(lcg_state);
    burst_data[0] = lcg_state;
    lcg_state = lcg_next(lcg_state);
    burst_data[2] = lcg_state;
    burst_data[1] = '0;
    bus_access(1'b1, burst_addr[0], burst_data[0], rd, rd_err);
    bus_access(1'b1, burst_addr[2], burst_data[2], rd, rd_err);
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      req  <= 1'b1;
      we   <= 1'b0;
      addr <= burst_addr[i];
      if (i > 0) begin
        @(negedge clk);
        check_response(burst_data[i-1], burst_err[i-1]);
      end
    end
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    check_response(burst_data[2], burst_err[2]);
    @(negedge clk);
    check_value("idle rsp_valid_o", 0, rsp_valid);
    end_test();
  endtask

  task automatic test_gpio_counter();
    int unsigned k;
    int unsigned wrap_base;
    logic        gpio_before;
    reg_data_t   rd;
    logic        rd_err;
    begin_test("gpio_counter");
    lcg_state = lcg_next(lcg_state);
    k = 1 + (lcg_state >> 8) % (CNT_MAX - 1);
    bus_access(1'b1, GPIO_BASE + OFS_CNT, '0, rd, rd_err);
    wrap_base = wrap_pulses;
    repeat (k) drive_gpio_edge();
    repeat (3) @(posedge clk);
    bus_access(1'b0, GPIO_BASE + OFS_CNT, '0, rd, rd_err);
    check_value("count after k edges", k, rd);
    check_value("early wrap pulses", 0, wrap_pulses - wrap_base);
    bus_access(1'b1, GPIO_BASE + OFS_CNT, '0, rd, rd_err);
    bus_access(1'b0, GPIO_BASE + OFS_CNT, '0, rd, rd_err);
    check_value("count after clear", 0, rd);
    gpio_before = gpio_out;
    repeat (CNT_MAX) drive_gpio_edge();
    repeat (3) @(posedge clk);
    bus_access(1'b0, GPIO_BASE + OFS_CNT, '0, rd, rd_err);
    check_value("count after wrap", 0, rd);
    check_value("gpio_o toggled", !gpio_before, gpio_out);
    check_value("wrap pulses", 1, wrap_pulses - wrap_base);
    end_test();
  endtask

  task automatic test_power_switch();
    logic [NUM_DOMAINS-1:0] old_vec;
    logic [NUM_DOMAINS-1:0] new_vec;
    int unsigned            lag;
    int unsigned            ack_base;
    reg_data_t              rd;
    logic                   rd_err;
    begin_test("power_switch");
    old_vec   = power_switch_n;
    lcg_state = lcg_next(lcg_state);
    new_vec   = NUM_DOMAINS'(lcg_state >> 16);
    if (new_vec == old_vec) new_vec = ~old_vec;
    ack_base = ack_pulses;
    bus_access(1'b1, POWER_BASE + OFS_SWITCH, reg_data_t'(new_vec), rd, rd_err);
    // Response cycle is the first cycle of the new request
    check_value("power_switch_n_o", new_vec, power_switch_n);
    lag = 0;
    while (power_ack_n !== new_vec && lag < 4 * ACK_LATENCY) begin
      check_value("power_ack_n_o held", old_vec, power_ack_n);
      @(negedge clk);
      lag++;
    end
    check_value("ack latency", ACK_LATENCY, lag);
    bus_access(1'b0, POWER_BASE + OFS_SWITCH, '0, rd, rd_err);
    check_value("switch read", new_vec, rd);
    bus_access(1'b0, POWER_BASE + OFS_ACK, '0, rd, rd_err);
    check_value("ack read", new_vec, rd);
    check_value("ack pulses", 1, ack_pulses - ack_base);
    end_test();
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    reset       = 1'b1;
    req         = 1'b0;
    we          = 1'b0;
    addr        = '0;
    wdata       = '0;
    gpio_in     = 1'b0;
    error_count = 0;
    check_count = 0;
    test_count  = 0;
    wrap_pulses = 0;
    ack_pulses  = 0;
    lcg_state   = 32'hb1b91565;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    test_reset_state();
    test_scratch_mem();
    test_addr_map();
    test_gpio_counter();
    test_power_switch();
    repeat (2) @(posedge clk);
    error_count = error_count + UUT.asserts_i.assert_errors;
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/ext_periph_harness_asserts.sv ====
////////////////////////////////////////
// Harness protocol assertions
////////////////////////////////////////

`default_nettype none

module ext_periph_harness_asserts #(
  parameter int unsigned NUM_DOMAINS = 4,
  parameter int unsigned ACK_LATENCY = 15
) (
  input logic                   clk_i,
  input logic                   reset_i,
  input logic                   req_i,
  input logic                   rsp_valid_i,
  input logic                   err_i,
  input logic [NUM_DOMAINS-1:0] switch_n_i,
  input logic [NUM_DOMAINS-1:0] ack_n_i
);

  int unsigned assert_errors = 0;
  int unsigned hist_cnt;

  // Cycles since reset until the ack line has refilled
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      hist_cnt <= 0;
    end else if (hist_cnt < ACK_LATENCY) begin
      hist_cnt <= hist_cnt + 1;
    end
  end

  rsp_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
    req_i |=> rsp_valid_i)
    else begin
      assert_errors++;
      $error("no response one cycle after a request");
    end

  no_extra_rsp: assert property (@(posedge clk_i) disable iff (reset_i)
    !req_i |=> !rsp_valid_i)
    else begin
      assert_errors++;
      $error("response without a request one cycle earlier");
    end

  err_with_rsp: assert property (@(posedge clk_i) disable iff (reset_i)
    err_i |-> rsp_valid_i)
    else begin
      assert_errors++;
      $error("err_o high outside a response cycle");
    end

  ack_delay: assert property (@(posedge clk_i) disable iff (reset_i)
    (hist_cnt == ACK_LATENCY) |-> (ack_n_i == $past(switch_n_i, ACK_LATENCY)))
    else begin
      assert_errors++;
      $error("power ack does not repeat the delayed switch request");
    end

endmodule

bind ext_periph_harness ext_periph_harness_asserts #(
  .NUM_DOMAINS(NUM_DOMAINS),
  .ACK_LATENCY(ACK_LATENCY)
) asserts_i (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .req_i      (req_i),
  .rsp_valid_i(rsp_valid_o),
  .err_i      (err_o),
  .switch_n_i (power_switch_n_o),
  .ack_n_i    (power_ack_n_o)
);

`default_nettype wire

// ==== hw/ext_periph_harness.sv ====
////////////////////////////////////////
// External peripheral harness
// Decoder, demux, peripherals, IRQs
////////////////////////////////////////

`default_nettype none

module ext_periph_harness
  import harness_pkg::*;
#(
  parameter int unsigned SCRATCH_WORDS = 64,
  parameter int unsigned CNT_MAX       = 8,
  parameter int unsigned NUM_DOMAINS   = 4,
  parameter int unsigned ACK_LATENCY   = 15
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  reg_addr_t              addr_i,
  input  reg_data_t              wdata_i,
  output logic                   rsp_valid_o,
  output reg_data_t              rdata_o,
  output logic                   err_o,
  input  logic                   gpio_i,
  output logic                   gpio_o,
  output logic [NUM_DOMAINS-1:0] power_switch_n_o,
  output logic [NUM_DOMAINS-1:0] power_ack_n_o,
  output logic [INTR_W-1:0]      intr_o
);

  periph_idx_t                  sel_idx;
  logic                         sel_valid;
  logic        [PERIPH_NUM-1:0] slot_req;
  reg_data_t   [PERIPH_NUM-1:0] slot_rdata;
  logic                         gpio_wrap;
  logic                         power_ack_settled;

  periph_addr_decode periph_addr_decode_i (
    .addr_i (addr_i),
    .idx_o  (sel_idx),
    .valid_o(sel_valid)
  );

  periph_reg_demux periph_reg_demux_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (req_i),
    .sel_idx_i   (sel_idx),
    .sel_valid_i (sel_valid),
    .slot_req_o  (slot_req),
    .slot_rdata_i(slot_rdata),
    .rsp_valid_o (rsp_valid_o),
    .rdata_o     (rdata_o),
    .err_o       (err_o)
  );

  scratch_ram #(
    .SCRATCH_WORDS(SCRATCH_WORDS)
  ) scratch_ram_i (
    .clk_i  (clk_i),
    .req_i  (slot_req[SCRATCH_IDX]),
    .we_i   (we_i),
    .addr_i (addr_i),
    .wdata_i(wdata_i),
    .rdata_o(slot_rdata[SCRATCH_IDX])
  );

  gpio_cnt #(
    .CNT_MAX(CNT_MAX)
  ) gpio_cnt_i (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .req_i  (slot_req[GPIO_CNT_IDX]),
    .we_i   (we_i),
    .wdata_i(wdata_i),
    .rdata_o(slot_rdata[GPIO_CNT_IDX]),
    .gpio_i (gpio_i),
    .gpio_o (gpio_o),
    .wrap_o (gpio_wrap)
  );

  switch_ack_model #(
    .NUM_DOMAINS(NUM_DOMAINS),
    .ACK_LATENCY(ACK_LATENCY)
  ) switch_ack_model_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_i           (slot_req[POWER_IDX]),
    .we_i            (we_i),
    .addr_i          (addr_i),
    .wdata_i         (wdata_i),
    .rdata_o         (slot_rdata[POWER_IDX]),
    .power_switch_n_o(power_switch_n_o),
    .power_ack_n_o   (power_ack_n_o),
    .ack_settled_o   (power_ack_settled)
  );

  // Interrupt vector
  always_comb begin
    intr_o                 = '0;
    intr_o[INTR_GPIO_WRAP] = gpio_wrap;
    intr_o[INTR_POWER_ACK] = power_ack_settled;
  end

endmodule

`default_nettype wire

// ==== hw/switch_ack_model.sv ====
////////////////////////////////////////
// Power switch model
// Request register, delayed acknowledge
////////////////////////////////////////

`default_nettype none

module switch_ack_model
  import harness_pkg::*;
#(
  parameter int unsigned NUM_DOMAINS = 4,
  parameter int unsigned ACK_LATENCY = 15
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  reg_addr_t              addr_i,
  input  reg_data_t              wdata_i,
  output reg_data_t              rdata_o,
  output logic [NUM_DOMAINS-1:0] power_switch_n_o,
  output logic [NUM_DOMAINS-1:0] power_ack_n_o,
  output logic                   ack_settled_o
);

  logic [NUM_DOMAINS-1:0] switch_q;
  logic [NUM_DOMAINS-1:0] ack_line_q [ACK_LATENCY];
  logic [NUM_DOMAINS-1:0] ack_n;
  logic                   sel_switch;
  logic                   sel_ack;
  logic                   match;
  logic                   match_q;
  reg_data_t              rdata_q;

  // Block is 16 bytes wide
  assign sel_switch = (addr_i[3:0] == OFS_SWITCH[3:0]);
  assign sel_ack    = (addr_i[3:0] == OFS_ACK[3:0]);

  // Active-low request that resets with all domains off
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      switch_q <= '1;
    end else if (req_i && we_i && sel_switch) begin
      switch_q <= wdata_i[NUM_DOMAINS-1:0];
    end
  end

  // Stands in for the switch cell delay
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < ACK_LATENCY; i++) begin
        ack_line_q[i] <= '1;
      end
    end else begin
      ack_line_q[0] <= switch_q;
      for (int i = 1; i < ACK_LATENCY; i++) begin
        ack_line_q[i] <= ack_line_q[i-1];
      end
    end
  end

  assign ack_n = ack_line_q[ACK_LATENCY-1];
  assign match = (ack_n == switch_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      match_q <= 1'b1;
    end else begin
      match_q <= match;
    end
  end

  // First cycle of agreement after a mismatch
  assign ack_settled_o = match && !match_q;

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        rdata_q <= '0;
      end else if (sel_switch) begin
        rdata_q <= REG_DATA_W'(switch_q);
      end else if (sel_ack) begin
        rdata_q <= REG_DATA_W'(ack_n);
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign rdata_o          = rdata_q;
  assign power_switch_n_o = switch_q;
  assign power_ack_n_o    = ack_n;

endmodule

`default_nettype wire

// ==== hw/gpio_cnt.sv ====
////////////////////////////////////////
// GPIO edge counter
// Counts rising edges, toggles on wrap
////////////////////////////////////////

`default_nettype none

module gpio_cnt
  import harness_pkg::*;
#(
  parameter int unsigned CNT_MAX = 8
) (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      req_i,
  input  logic      we_i,
  input  reg_data_t wdata_i,
  output reg_data_t rdata_o,
  input  logic      gpio_i,
  output logic      gpio_o,
  output logic      wrap_o
);

  localparam int unsigned CNT_W = $clog2(CNT_MAX + 1);

  logic             sync_q1;
  logic             sync_q2;
  logic             rise;
  logic             at_last;
  logic [CNT_W-1:0] cnt_q;
  logic             gpio_q;
  logic             wrap_q;
  reg_data_t        rdata_q;

  assign rise    = sync_q1 && !sync_q2;
  assign at_last = (cnt_q == CNT_W'(CNT_MAX - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
      cnt_q   <= '0;
      gpio_q  <= 1'b0;
      wrap_q  <= 1'b0;
    end else begin
      sync_q1 <= gpio_i;
      sync_q2 <= sync_q1;
      wrap_q  <= 1'b0;
      // Clear by write has priority over an edge
      if (req_i && we_i) begin
        cnt_q <= '0;
      end else if (rise) begin
        if (at_last) begin
          cnt_q  <= '0;
          gpio_q <= !gpio_q;
          wrap_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  // Writes clear the count and answer with zero
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= we_i ? '0 : REG_DATA_W'(cnt_q);
    end
  end

  assign rdata_o = rdata_q;
  assign gpio_o  = gpio_q;
  assign wrap_o  = wrap_q;

endmodule

`default_nettype wire

// ==== hw/scratch_ram.sv ====
////////////////////////////////////////
// Scratch memory peripheral
// Word-addressed read/write storage
////////////////////////////////////////

`default_nettype none

module scratch_ram
  import harness_pkg::*;
#(
  parameter int unsigned SCRATCH_WORDS = 64
) (
  input  logic      clk_i,
  input  logic      req_i,
  input  logic      we_i,
  input  reg_addr_t addr_i,
  input  reg_data_t wdata_i,
  output reg_data_t rdata_o
);

  localparam int unsigned WORD_AW = $clog2(SCRATCH_WORDS);

  reg_data_t              mem [SCRATCH_WORDS];
  logic     [WORD_AW-1:0] word_idx;
  reg_data_t              rdata_q;

  // Byte address to word index
  assign word_idx = addr_i[WORD_AW+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem[word_idx] <= wdata_i;
    end
  end

  // Writes answer with zero
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= we_i ? '0 : mem[word_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== hw/periph_reg_demux.sv ====
////////////////////////////////////////
// Register demultiplexer
// Routes strobes, returns slot responses
////////////////////////////////////////

`default_nettype none

module periph_reg_demux
  import harness_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             req_i,
  input  periph_idx_t                      sel_idx_i,
  input  logic                             sel_valid_i,
  output logic        [PERIPH_NUM-1:0]     slot_req_o,
  input  reg_data_t   [PERIPH_NUM-1:0]     slot_rdata_i,
  output logic                             rsp_valid_o,
  output reg_data_t                        rdata_o,
  output logic                             err_o
);

  logic        rsp_valid_q;
  logic        err_q;
  periph_idx_t idx_q;

  // Strobe goes to the selected slot only
  always_comb begin
    for (int i = 0; i < PERIPH_NUM; i++) begin
      slot_req_o[i] = req_i && sel_valid_i && (sel_idx_i == periph_idx_t'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
      err_q       <= 1'b0;
    end else begin
      rsp_valid_q <= req_i;
      err_q       <= req_i && !sel_valid_i;
    end
  end

  // Selection kept for the response cycle
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      idx_q <= sel_idx_i;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign err_o       = err_q;

  // Unmapped accesses return zero
  assign rdata_o = (rsp_valid_q && !err_q) ? slot_rdata_i[idx_q] : '0;

endmodule

`default_nettype wire

// ==== hw/periph_addr_decode.sv ====
////////////////////////////////////////
// Peripheral address decoder
// Finds the slot that owns an address
////////////////////////////////////////

`default_nettype none

module periph_addr_decode
  import harness_pkg::*;
(
  input  reg_addr_t   addr_i,
  output periph_idx_t idx_o,
  output logic        valid_o
);

  logic [PERIPH_NUM-1:0] rule_hit;

  // One comparator pair per rule
  always_comb begin
    for (int i = 0; i < PERIPH_NUM; i++) begin
      rule_hit[i] = (addr_i >= PERIPH_ADDR_RULES[i].start_addr) &&
                    (addr_i < PERIPH_ADDR_RULES[i].end_addr);
    end
  end

  // Rules do not overlap, so at most one hit
  always_comb begin
    idx_o   = '0;
    valid_o = 1'b0;
    for (int i = 0; i < PERIPH_NUM; i++) begin
      if (rule_hit[i]) begin
        idx_o   = PERIPH_ADDR_RULES[i].idx;
        valid_o = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/harness_pkg.sv ====
////////////////////////////////////////
// Harness package
// Bus widths, address map, slot indices
////////////////////////////////////////

`default_nettype none

package harness_pkg;

  // Register bus
  localparam int unsigned REG_ADDR_W = 12;
  localparam int unsigned REG_DATA_W = 32;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [REG_DATA_W-1:0] reg_data_t;

  // Peripheral slots
  localparam int unsigned PERIPH_NUM   = 3;
  localparam int unsigned PERIPH_IDX_W = 2;

  typedef logic [PERIPH_IDX_W-1:0] periph_idx_t;

  localparam periph_idx_t SCRATCH_IDX  = 2'd0;
  localparam periph_idx_t GPIO_CNT_IDX = 2'd1;
  localparam periph_idx_t POWER_IDX    = 2'd2;

  // End address is exclusive
  typedef struct packed {
    periph_idx_t idx;
    reg_addr_t   start_addr;
    reg_addr_t   end_addr;
  } addr_rule_t;

  localparam addr_rule_t [PERIPH_NUM-1:0] PERIPH_ADDR_RULES = '{
    '{idx: POWER_IDX, start_addr: 12'h200, end_addr: 12'h210},
    '{idx: GPIO_CNT_IDX, start_addr: 12'h100, end_addr: 12'h110},
    '{idx: SCRATCH_IDX, start_addr: 12'h000, end_addr: 12'h100}
  };

  // Register offsets inside a block
  localparam reg_addr_t OFS_CNT    = 12'h000;
  localparam reg_addr_t OFS_SWITCH = 12'h000;
  localparam reg_addr_t OFS_ACK    = 12'h004;

  // Interrupt vector
  localparam int unsigned INTR_W         = 2;
  localparam int unsigned INTR_GPIO_WRAP = 0;
  localparam int unsigned INTR_POWER_ACK = 1;

endpackage

`default_nettype wire
